/* mcast_demux_defs.svh */
/*
 * Multicast write demultiplexer parameters
 * Port count, bus field widths and the depth of the selection queues
 */

`ifndef MCAST_DEMUX_DEFS_SVH
`define MCAST_DEMUX_DEFS_SVH

// Number of master ports
`define MCAST_NUM_PORTS 4

// Bus field widths
`define MCAST_ADDR_W 32
`define MCAST_DATA_W 32
`define MCAST_ID_W   4
`define MCAST_LEN_W  8

// Writes in flight, sizes the route and join queues
`define MCAST_MAX_TRANS 4

`endif

/* mcast_bus_pkg.sv */
/*
 * Bus types of the multicast write demultiplexer
 * Beat layouts of the AW, W and B channels and the response codes
 */

`include "mcast_demux_defs.svh"

package mcast_bus_pkg;

  typedef logic [`MCAST_ADDR_W-1:0] addr_t;
  typedef logic [`MCAST_DATA_W-1:0] data_t;
  typedef logic [`MCAST_ID_W-1:0]   id_t;
  typedef logic [`MCAST_LEN_W-1:0]  len_t;

  // Ordered by code value, not by severity
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Slave side AW, collective_mask marks don't-care address bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    addr_t collective_mask;
  } aw_beat_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_beat_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_beat_t;

  // Per-port AW with sub-address and remaining multicast mask
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    addr_t mask;
  } port_aw_t;

endpackage

/* mcast_map_pkg.sv */
/*
 * Address map types of the multicast write demultiplexer
 * Port masks, interval rules and the decode result passed downstream
 */

`include "mcast_demux_defs.svh"

package mcast_map_pkg;

  import mcast_bus_pkg::*;

  typedef logic [`MCAST_NUM_PORTS-1:0] port_mask_t;
  typedef logic [(`MCAST_NUM_PORTS > 1 ? $clog2(`MCAST_NUM_PORTS) : 1)-1:0] port_idx_t;

  // Half-open interval, rule i targets port i
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } addr_rule_t;

  // Decode result of one AW
  typedef struct packed {
    port_mask_t                          sel;
    logic                                dec_err;
    id_t                                 id;
    port_aw_t [`MCAST_NUM_PORTS-1:0]     aw;
  } route_t;

endpackage

/* aw_spill_reg.sv */
/*
 * AW spill register
 * Two slots, registers both valid and ready paths and still
 * passes one beat per cycle
 */

`timescale 1ns/1ps

module aw_spill_reg import mcast_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  aw_beat_t aw_i,
  input  logic     valid_i,
  output logic     ready_o,
  output aw_beat_t aw_o,
  output logic     valid_o,
  input  logic     ready_i
);

  aw_beat_t a_data_q, b_data_q;
  logic     a_full_q, b_full_q;
  logic     a_fill, a_drain, b_fill, b_drain;

  // Slot A takes input, slot B catches A when output stalls
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= aw_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B always holds the older beat
  assign valid_o = a_full_q || b_full_q;
  assign aw_o    = b_full_q ? b_data_q : a_data_q;
  assign ready_o = !a_full_q || !b_full_q;

endmodule

/* aw_addr_decode.sv */
/*
 * AW address decoder
 * Unicast beats match the first interval rule, multicast beats match
 * every rule read as an aligned power-of-two mask. Produces the port
 * selection and the per-port sub-address and mask
 */

`timescale 1ns/1ps

`include "mcast_demux_defs.svh"

module aw_addr_decode import mcast_bus_pkg::*; import mcast_map_pkg::*; (
  input  aw_beat_t                          aw_i,
  input  logic                              valid_i,
  output logic                              ready_o,
  input  addr_rule_t [`MCAST_NUM_PORTS-1:0] addr_map_i,
  input  logic                              en_default_port_i,
  input  port_idx_t                         default_port_i,
  output route_t                            route_o,
  output logic                              valid_o,
  input  logic                              ready_i
);

  // Pure combinational stage, handshake passes through
  assign valid_o = valid_i;
  assign ready_o = ready_i;

  always_comb begin : p_decode
    logic      hit;
    port_idx_t hit_idx;
    addr_t     rule_mask;
    addr_t     aw_only;

    hit       = 1'b0;
    hit_idx   = '0;
    rule_mask = '0;
    aw_only   = '0;
    route_o   = '0;
    route_o.id = aw_i.id;

    if (aw_i.collective_mask == '0) begin
      // ------------------------------
      // Unicast
      // ------------------------------
      for (int i = 0; i < `MCAST_NUM_PORTS; i++) begin
        if (!hit && aw_i.addr >= addr_map_i[i].start_addr &&
            aw_i.addr < addr_map_i[i].end_addr) begin
          hit     = 1'b1;
          hit_idx = port_idx_t'(i);
        end
      end
      // Fall back to the default port on a miss
      if (!hit && en_default_port_i) begin
        hit     = 1'b1;
        hit_idx = default_port_i;
      end
      for (int i = 0; i < `MCAST_NUM_PORTS; i++) begin
        route_o.aw[i].id   = aw_i.id;
        route_o.aw[i].addr = aw_i.addr;
        route_o.aw[i].len  = aw_i.len;
        route_o.aw[i].mask = '0;
      end
      if (hit) begin
        route_o.sel[hit_idx] = 1'b1;
      end else begin
        route_o.dec_err = 1'b1;
      end
    end else begin
      // ------------------------------
      // Multicast
      // ------------------------------
      for (int i = 0; i < `MCAST_NUM_PORTS; i++) begin
        rule_mask = addr_map_i[i].end_addr - addr_map_i[i].start_addr - 1;
        // Bits the request wildcards but the rule pins down
        aw_only   = aw_i.collective_mask & ~rule_mask;
        route_o.sel[i] = ((aw_i.addr ^ addr_map_i[i].start_addr) &
                          ~(aw_i.collective_mask | rule_mask)) == '0;
        route_o.aw[i].id   = aw_i.id;
        route_o.aw[i].len  = aw_i.len;
        route_o.aw[i].addr = (addr_map_i[i].start_addr & aw_only) |
                             (aw_i.addr & ~aw_only);
        route_o.aw[i].mask = aw_i.collective_mask & rule_mask;
      end
      route_o.dec_err = (route_o.sel == '0);
    end
  end

endmodule

/* w_route.sv */
/*
 * Write router
 * Queues decoded selections, forks each AW to its selected ports and
 * broadcasts the W burst to the same ports until the last beat.
 * Pushes the selection on to the B join as each AW is accepted
 */

`timescale 1ns/1ps

`include "mcast_demux_defs.svh"

module w_route import mcast_bus_pkg::*; import mcast_map_pkg::*; (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  route_t                          route_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  input  w_beat_t                         w_i,
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  output port_aw_t [`MCAST_NUM_PORTS-1:0] mst_aw_o,
  output port_mask_t                      mst_aw_valid_o,
  input  port_mask_t                      mst_aw_ready_i,
  output w_beat_t  [`MCAST_NUM_PORTS-1:0] mst_w_o,
  output port_mask_t                      mst_w_valid_o,
  input  port_mask_t                      mst_w_ready_i,
  output logic                            join_push_o,
  output route_t                          join_o,
  input  logic                            join_ready_i
);

  localparam int unsigned DEPTH = `MCAST_MAX_TRANS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  route_t     queue_q [DEPTH];
  ptr_t       wr_ptr_q, rd_ptr_q;
  cnt_t       count_q;
  route_t     head;
  logic       head_valid, push, pop;

  logic       armed_q, w_done_q;
  port_mask_t aw_pend_q, w_taken_q, w_port_fire;
  logic       w_active, w_fire, w_last_fire;

  // ------------------------------
  // Selection queue
  // ------------------------------
  assign head       = queue_q[rd_ptr_q];
  assign head_valid = (count_q != '0);
  // Join queue is the same size, stall on either being full
  assign ready_o    = (count_q != cnt_t'(DEPTH)) && join_ready_i;
  assign push       = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (push) queue_q[wr_ptr_q] <= route_i;
  end

  // B join only needs the selection and the ID
  assign join_push_o = push;
  always_comb begin
    join_o         = '0;
    join_o.sel     = route_i.sel;
    join_o.dec_err = route_i.dec_err;
    join_o.id      = route_i.id;
  end

  // ------------------------------
  // AW fork and W broadcast
  // ------------------------------
  assign mst_aw_o       = head.aw;
  assign mst_aw_valid_o = aw_pend_q;

  for (genvar i = 0; i < `MCAST_NUM_PORTS; i++) begin : g_w_fanout
    assign mst_w_o[i] = w_i;
  end

  assign w_active      = head_valid && armed_q && !w_done_q;
  assign mst_w_valid_o = {`MCAST_NUM_PORTS{w_valid_i && w_active}} & head.sel & ~w_taken_q;
  assign w_port_fire   = mst_w_valid_o & mst_w_ready_i;
  // Error entries have no ports selected and sink W at once
  assign w_ready_o     = w_active &&
                         (head.dec_err || (((w_taken_q | w_port_fire) & head.sel) == head.sel));
  assign w_fire        = w_valid_i && w_ready_o;
  assign w_last_fire   = w_fire && w_i.last;

  // Retire once the burst is done and every port took the AW
  assign pop = head_valid && armed_q && (w_done_q || w_last_fire) &&
               ((aw_pend_q & ~mst_aw_ready_i) == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      armed_q   <= 1'b0;
      w_done_q  <= 1'b0;
      aw_pend_q <= '0;
      w_taken_q <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + cnt_t'(push) - cnt_t'(pop);

      if (pop) begin
        armed_q   <= 1'b0;
        w_done_q  <= 1'b0;
        aw_pend_q <= '0;
        w_taken_q <= '0;
      end else begin
        // New head offers its AW one cycle after reaching the head
        if (head_valid && !armed_q) begin
          armed_q   <= 1'b1;
          aw_pend_q <= head.sel;
        end else begin
          aw_pend_q <= aw_pend_q & ~mst_aw_ready_i;
        end
        if (w_fire) begin
          w_taken_q <= '0;
        end else begin
          w_taken_q <= w_taken_q | w_port_fire;
        end
        if (w_last_fire) w_done_q <= 1'b1;
      end
    end
  end

endmodule

/* b_join.sv */
/*
 * B response join
 * Waits for a B from every port of the oldest write, merges them into
 * one upstream B with the worst code, or answers DECERR on its own
 */

`timescale 1ns/1ps

`include "mcast_demux_defs.svh"

module b_join import mcast_bus_pkg::*; import mcast_map_pkg::*; (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            push_i,
  input  route_t                          route_i,
  output logic                            ready_o,
  input  b_beat_t  [`MCAST_NUM_PORTS-1:0] mst_b_i,
  input  port_mask_t                      mst_b_valid_i,
  output port_mask_t                      mst_b_ready_o,
  output b_beat_t                         slv_b_o,
  output logic                            slv_b_valid_o,
  input  logic                            slv_b_ready_i
);

  localparam int unsigned DEPTH = `MCAST_MAX_TRANS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  // Severity order EXOKAY < OKAY < SLVERR < DECERR
  function automatic logic [1:0] rank(input resp_e resp);
    case (resp)
      RESP_EXOKAY: return 2'd0;
      RESP_OKAY:   return 2'd1;
      RESP_SLVERR: return 2'd2;
      default:     return 2'd3;
    endcase
  endfunction

  port_mask_t sel_q [DEPTH];
  logic       err_q [DEPTH];
  id_t        id_q  [DEPTH];
  ptr_t       wr_ptr_q, rd_ptr_q;
  cnt_t       count_q;
  logic       head_valid, push, pop;

  port_mask_t answered_q, b_fire;
  resp_e      resp_q, resp_merged;

  assign head_valid = (count_q != '0);
  assign ready_o    = (count_q != cnt_t'(DEPTH));
  assign push       = push_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      sel_q[wr_ptr_q] <= route_i.sel;
      err_q[wr_ptr_q] <= route_i.dec_err;
      id_q[wr_ptr_q]  <= route_i.id;
    end
  end

  // Only the head's ports are accepted, one B each
  assign mst_b_ready_o = {`MCAST_NUM_PORTS{head_valid && !err_q[rd_ptr_q]}} &
                         sel_q[rd_ptr_q] & ~answered_q;
  assign b_fire        = mst_b_valid_i & mst_b_ready_o;

  always_comb begin
    resp_merged = resp_q;
    for (int i = 0; i < `MCAST_NUM_PORTS; i++) begin
      if (b_fire[i] && rank(mst_b_i[i].resp) > rank(resp_merged)) begin
        resp_merged = mst_b_i[i].resp;
      end
    end
  end

  assign slv_b_valid_o = head_valid &&
                         (err_q[rd_ptr_q] || ((answered_q & sel_q[rd_ptr_q]) == sel_q[rd_ptr_q]));
  assign slv_b_o.id    = id_q[rd_ptr_q];
  assign slv_b_o.resp  = err_q[rd_ptr_q] ? RESP_DECERR : resp_q;
  assign pop           = slv_b_valid_o && slv_b_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      answered_q <= '0;
      resp_q     <= RESP_EXOKAY;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + cnt_t'(push) - cnt_t'(pop);
      if (pop) begin
        answered_q <= '0;
        resp_q     <= RESP_EXOKAY;
      end else begin
        answered_q <= answered_q | b_fire;
        resp_q     <= resp_merged;
      end
    end
  end

endmodule

/* mcast_demux_top.sv */
/*
 * Multicast write demultiplexer
 * One slave write port to MCAST_NUM_PORTS master ports through
 * spill, decode, route and B join stages
 */

`timescale 1ns/1ps

`include "mcast_demux_defs.svh"

module mcast_demux_top import mcast_bus_pkg::*; import mcast_map_pkg::*; (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Configuration
  input  addr_rule_t [`MCAST_NUM_PORTS-1:0] addr_map_i,
  input  logic                              en_default_port_i,
  input  port_idx_t                         default_port_i,
  // Slave port
  input  aw_beat_t                          slv_aw_i,
  input  logic                              slv_aw_valid_i,
  output logic                              slv_aw_ready_o,
  input  w_beat_t                           slv_w_i,
  input  logic                              slv_w_valid_i,
  output logic                              slv_w_ready_o,
  output b_beat_t                           slv_b_o,
  output logic                              slv_b_valid_o,
  input  logic                              slv_b_ready_i,
  // Master ports
  output port_aw_t   [`MCAST_NUM_PORTS-1:0] mst_aw_o,
  output port_mask_t                        mst_aw_valid_o,
  input  port_mask_t                        mst_aw_ready_i,
  output w_beat_t    [`MCAST_NUM_PORTS-1:0] mst_w_o,
  output port_mask_t                        mst_w_valid_o,
  input  port_mask_t                        mst_w_ready_i,
  input  b_beat_t    [`MCAST_NUM_PORTS-1:0] mst_b_i,
  input  port_mask_t                        mst_b_valid_i,
  output port_mask_t                        mst_b_ready_o
);

  aw_beat_t spill_aw;
  logic     spill_valid, spill_ready;
  route_t   dec_route;
  logic     dec_valid, dec_ready;
  route_t   join_route;
  logic     join_push, join_ready;

  aw_spill_reg aw_spill_reg_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .aw_i     (slv_aw_i),
    .valid_i  (slv_aw_valid_i),
    .ready_o  (slv_aw_ready_o),
    .aw_o     (spill_aw),
    .valid_o  (spill_valid),
    .ready_i  (spill_ready)
  );

  aw_addr_decode aw_addr_decode_inst (
    .aw_i              (spill_aw),
    .valid_i           (spill_valid),
    .ready_o           (spill_ready),
    .addr_map_i        (addr_map_i),
    .en_default_port_i (en_default_port_i),
    .default_port_i    (default_port_i),
    .route_o           (dec_route),
    .valid_o           (dec_valid),
    .ready_i           (dec_ready)
  );

  w_route w_route_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .route_i        (dec_route),
    .valid_i        (dec_valid),
    .ready_o        (dec_ready),
    .w_i            (slv_w_i),
    .w_valid_i      (slv_w_valid_i),
    .w_ready_o      (slv_w_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .join_push_o    (join_push),
    .join_o         (join_route),
    .join_ready_i   (join_ready)
  );

  b_join b_join_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .push_i        (join_push),
    .route_i       (join_route),
    .ready_o       (join_ready),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i)
  );

endmodule

/* mcast_demux_assertions.sv */
/*
 * Handshake checks of the multicast write demultiplexer
 * Valid and payload hold until ready, and no valid during reset
 */

`timescale 1ns/1ps

`include "mcast_demux_defs.svh"

module mcast_demux_assertions import mcast_bus_pkg::*; import mcast_map_pkg::*; (
  input logic                              clk_i,
  input logic                              arst_n_i,
  input b_beat_t                           slv_b_o,
  input logic                              slv_b_valid_o,
  input logic                              slv_b_ready_i,
  input port_aw_t [`MCAST_NUM_PORTS-1:0]   mst_aw_o,
  input port_mask_t                        mst_aw_valid_o,
  input port_mask_t                        mst_aw_ready_i,
  input w_beat_t  [`MCAST_NUM_PORTS-1:0]   mst_w_o,
  input port_mask_t                        mst_w_valid_o,
  input port_mask_t                        mst_w_ready_i
);

  // Upstream B
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_b_valid_o && !slv_b_ready_i |=> slv_b_valid_o && $stable(slv_b_o))
  else $error("slave B dropped or changed before it was taken");

  for (genvar i = 0; i < `MCAST_NUM_PORTS; i++) begin : g_port
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_aw_valid_o[i] && !mst_aw_ready_i[i] |=> mst_aw_valid_o[i] && $stable(mst_aw_o[i]))
    else $error("master AW %0d dropped or changed before it was taken", i);

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mst_w_valid_o[i] && !mst_w_ready_i[i] |=> mst_w_valid_o[i] && $stable(mst_w_o[i]))
    else $error("master W %0d dropped or changed before it was taken", i);
  end

  assert property (@(posedge clk_i)
    !arst_n_i |-> !slv_b_valid_o && mst_aw_valid_o == '0 && mst_w_valid_o == '0)
  else $error("valid raised while reset is asserted");

endmodule

bind mcast_demux_top mcast_demux_assertions mcast_demux_assertions_inst (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .slv_b_o        (slv_b_o),
  .slv_b_valid_o  (slv_b_valid_o),
  .slv_b_ready_i  (slv_b_ready_i),
  .mst_aw_o       (mst_aw_o),
  .mst_aw_valid_o (mst_aw_valid_o),
  .mst_aw_ready_i (mst_aw_ready_i),
  .mst_w_o        (mst_w_o),
  .mst_w_valid_o  (mst_w_valid_o),
  .mst_w_ready_i  (mst_w_ready_i)
);

/* mcast_demux_tb.sv */
/*
 * Testbench of the multicast write demultiplexer
 * Drives the slave port, models the master ports with programmable
 * B codes and random stalls, and runs directed write tests
 */

`timescale 1ns/1ps

`include "mcast_demux_defs.svh"

module mcast_demux_tb import mcast_bus_pkg::*; import mcast_map_pkg::*;;

  localparam int NP               = `MCAST_NUM_PORTS;
  localparam int CLK_PERIOD_NS    = 100;
  localparam int NUM_WRITES       = 10;
  localparam int CYCLES_PER_WRITE = 200;
  localparam int TIMEOUT_NS       = (NUM_WRITES * CYCLES_PER_WRITE + 10) * CLK_PERIOD_NS;

  typedef data_t data_q_t [$];

  logic                 clk          = 1'b0;
  logic                 arst_n;
  addr_rule_t [NP-1:0]  addr_map     = '0;
  logic                 en_default   = 1'b0;
  port_idx_t            default_port = '0;
  aw_beat_t             slv_aw       = '0;
  logic                 slv_aw_valid = 1'b0;
  logic                 slv_aw_ready;
  w_beat_t              slv_w        = '0;
  logic                 slv_w_valid  = 1'b0;
  logic                 slv_w_ready;
  b_beat_t              slv_b;
  logic                 slv_b_valid;
  logic                 slv_b_ready  = 1'b0;
  port_aw_t [NP-1:0]    mst_aw;
  port_mask_t           mst_aw_valid;
  port_mask_t           mst_aw_ready = '0;
  w_beat_t  [NP-1:0]    mst_w;
  port_mask_t           mst_w_valid;
  port_mask_t           mst_w_ready  = '0;
  b_beat_t  [NP-1:0]    mst_b        = '0;
  port_mask_t           mst_b_valid  = '0;
  port_mask_t           mst_b_ready;

  integer   seed     = 32'hc888;
  logic     stall_en = 1'b0;
  resp_e    resp_code [NP] = '{default: RESP_OKAY};
  port_aw_t aw_log [NP][$];
  w_beat_t  w_log [NP][$];
  id_t      b_ids [NP][$];
  int       b_due [NP] = '{default: 0};
  b_beat_t  b_log [$];

  mcast_demux_top mcast_demux_top_inst (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .addr_map_i        (addr_map),
    .en_default_port_i (en_default),
    .default_port_i    (default_port),
    .slv_aw_i          (slv_aw),
    .slv_aw_valid_i    (slv_aw_valid),
    .slv_aw_ready_o    (slv_aw_ready),
    .slv_w_i           (slv_w),
    .slv_w_valid_i     (slv_w_valid),
    .slv_w_ready_o     (slv_w_ready),
    .slv_b_o           (slv_b),
    .slv_b_valid_o     (slv_b_valid),
    .slv_b_ready_i     (slv_b_ready),
    .mst_aw_o          (mst_aw),
    .mst_aw_valid_o    (mst_aw_valid),
    .mst_aw_ready_i    (mst_aw_ready),
    .mst_w_o           (mst_w),
    .mst_w_valid_o     (mst_w_valid),
    .mst_w_ready_i     (mst_w_ready),
    .mst_b_i           (mst_b),
    .mst_b_valid_i     (mst_b_valid),
    .mst_b_ready_o     (mst_b_ready)
  );

  initial begin : clock_gen
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  function automatic logic draw_ready();
    if (!stall_en) return 1'b1;
    return ($random(seed) & 3) != 0;
  endfunction

  // ------------------------------
  // Master port models
  // ------------------------------
  always @(posedge clk) begin : port_model
    b_beat_t nb;
    for (int p = 0; p < NP; p++) begin
      if (mst_aw_valid[p] && mst_aw_ready[p]) begin
        aw_log[p].push_back(mst_aw[p]);
        b_ids[p].push_back(mst_aw[p].id);
      end
      if (mst_w_valid[p] && mst_w_ready[p]) begin
        w_log[p].push_back(mst_w[p]);
        if (mst_w[p].last) b_due[p]++;
      end
      if (mst_b_valid[p] && mst_b_ready[p]) begin
        void'(b_ids[p].pop_front());
        b_due[p]--;
        mst_b_valid[p] <= 1'b0;
      end
      // One B per finished burst, held until taken
      if ((!mst_b_valid[p] || mst_b_ready[p]) && b_due[p] > 0 && b_ids[p].size() > 0) begin
        nb.id          = b_ids[p][0];
        nb.resp        = resp_code[p];
        mst_b[p]       <= nb;
        mst_b_valid[p] <= 1'b1;
      end
      mst_aw_ready[p] <= draw_ready();
      mst_w_ready[p]  <= draw_ready();
    end
  end

  always @(posedge clk) begin : b_monitor
    if (slv_b_valid && slv_b_ready) b_log.push_back(slv_b);
    slv_b_ready <= draw_ready();
  end

  // ------------------------------
  // Slave side drivers
  // ------------------------------
  function automatic aw_beat_t make_aw(input id_t id, input addr_t addr, input len_t len,
                                       input addr_t mask);
    aw_beat_t aw;
    aw.id              = id;
    aw.addr            = addr;
    aw.len             = len;
    aw.collective_mask = mask;
    return aw;
  endfunction

  function automatic data_q_t random_beats(input int n);
    data_q_t q;
    for (int i = 0; i < n; i++) q.push_back($random(seed));
    return q;
  endfunction

  task automatic drive_aw(input aw_beat_t aw);
    slv_aw       <= aw;
    slv_aw_valid <= 1'b1;
    @(posedge clk);
    while (!slv_aw_ready) @(posedge clk);
    slv_aw_valid <= 1'b0;
  endtask

  task automatic push_w_burst(input data_q_t beats);
    w_beat_t beat;
    for (int i = 0; i < beats.size(); i++) begin
      beat.data   = beats[i];
      beat.last   = (i == beats.size() - 1);
      slv_w       <= beat;
      slv_w_valid <= 1'b1;
      @(posedge clk);
      while (!slv_w_ready) @(posedge clk);
    end
    slv_w_valid <= 1'b0;
  endtask

  task automatic run_write(input aw_beat_t aw, input data_q_t beats);
    fork
      drive_aw(aw);
      push_w_burst(beats);
    join
  endtask

  task automatic await_b(input int count);
    while (b_log.size() < count) @(posedge clk);
  endtask

  task automatic clear_logs();
    for (int p = 0; p < NP; p++) begin
      aw_log[p].delete();
      w_log[p].delete();
    end
    b_log.delete();
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic verify_counts(input string name, input int port, input int n_aw,
                               input int n_w);
    compare_values($sformatf("%s p%0d aw count", name, port), n_aw, aw_log[port].size());
    compare_values($sformatf("%s p%0d w count", name, port), n_w, w_log[port].size());
  endtask

  task automatic verify_port_write(input string name, input int port, input int aw_idx,
                                   input int w_idx, input addr_t exp_addr,
                                   input addr_t exp_mask, input aw_beat_t aw,
                                   input data_q_t beats);
    port_aw_t got;
    got = aw_log[port][aw_idx];
    compare_values({name, " id"}, 32'(aw.id), 32'(got.id));
    compare_values({name, " addr"}, exp_addr, got.addr);
    compare_values({name, " len"}, 32'(aw.len), 32'(got.len));
    compare_values({name, " mask"}, exp_mask, got.mask);
    for (int i = 0; i < beats.size(); i++) begin
      compare_values({name, " data"}, beats[i], w_log[port][w_idx + i].data);
      compare_values({name, " last"}, 32'(i == beats.size() - 1),
                     32'(w_log[port][w_idx + i].last));
    end
  endtask

  task automatic expect_b(input string name, input int idx, input id_t id, input resp_e resp);
    compare_values({name, " b id"}, 32'(id), 32'(b_log[idx].id));
    compare_values({name, " b resp"}, 32'(resp), 32'(b_log[idx].resp));
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic unicast_writes();
    aw_beat_t aw;
    data_q_t  beats;
    string    name;
    for (int p = 0; p < NP; p++) begin
      clear_logs();
      name  = $sformatf("unicast p%0d", p);
      beats = random_beats(2);
      aw    = make_aw(id_t'(p + 1), addr_map[p].start_addr + 32'h40, 8'd1, '0);
      run_write(aw, beats);
      await_b(1);
      for (int q = 0; q < NP; q++) verify_counts(name, q, (q == p) ? 1 : 0, (q == p) ? 2 : 0);
      verify_port_write(name, p, 0, 0, aw.addr, '0, aw, beats);
      expect_b(name, 0, aw.id, RESP_OKAY);
    end
  endtask

  task automatic decode_error_write();
    aw_beat_t aw;
    data_q_t  beats;
    clear_logs();
    beats = random_beats(3);
    aw    = make_aw(4'h5, 32'h2000_0100, 8'd2, '0);
    run_write(aw, beats);
    await_b(1);
    for (int q = 0; q < NP; q++) verify_counts("decerr", q, 0, 0);
    expect_b("decerr", 0, aw.id, RESP_DECERR);
  endtask

  task automatic default_port_write();
    aw_beat_t aw;
    data_q_t  beats;
    clear_logs();
    en_default   <= 1'b1;
    default_port <= port_idx_t'(2);
    beats = random_beats(1);
    aw    = make_aw(4'h6, 32'h2000_0200, 8'd0, '0);
    run_write(aw, beats);
    await_b(1);
    for (int q = 0; q < NP; q++) verify_counts("default", q, (q == 2) ? 1 : 0, (q == 2) ? 1 : 0);
    verify_port_write("default p2", 2, 0, 0, aw.addr, '0, aw, beats);
    expect_b("default", 0, aw.id, RESP_OKAY);
    en_default <= 1'b0;
  endtask

  task automatic multicast_write();
    aw_beat_t aw;
    data_q_t  beats;
    clear_logs();
    resp_code[2] = RESP_SLVERR;
    beats = random_beats(2);
    // Bit 12 spans rules 1 and 2, bits 3:2 stay wildcarded at the ports
    aw = make_aw(4'h9, 32'h1000_2040, 8'd1, 32'h0000_100c);
    run_write(aw, beats);
    await_b(1);
    for (int q = 0; q < NP; q++) begin
      verify_counts("mcast", q, (q == 1 || q == 2) ? 1 : 0, (q == 1 || q == 2) ? 2 : 0);
    end
    verify_port_write("mcast p1", 1, 0, 0, 32'h1000_2040, 32'h0000_000c, aw, beats);
    verify_port_write("mcast p2", 2, 0, 0, 32'h1000_3040, 32'h0000_000c, aw, beats);
    expect_b("mcast", 0, aw.id, RESP_SLVERR);
    resp_code[2] = RESP_OKAY;
  endtask

  task automatic backpressure_order();
    aw_beat_t aw_a, aw_b, aw_c;
    data_q_t  qa, qb, qc;
    clear_logs();
    stall_en = 1'b1;
    qa   = random_beats(4);
    qb   = random_beats(3);
    qc   = random_beats(2);
    aw_a = make_aw(4'h1, addr_map[0].start_addr + 32'h100, 8'd3, '0);
    aw_b = make_aw(4'h2, addr_map[3].start_addr + 32'h080, 8'd2, '0);
    aw_c = make_aw(4'h3, addr_map[0].start_addr + 32'h200, 8'd1, '0);
    fork
      begin
        drive_aw(aw_a);
        drive_aw(aw_b);
        drive_aw(aw_c);
      end
      begin
        push_w_burst(qa);
        push_w_burst(qb);
        push_w_burst(qc);
      end
    join
    await_b(3);
    stall_en = 1'b0;
    verify_counts("order", 0, 2, 6);
    verify_counts("order", 1, 0, 0);
    verify_counts("order", 2, 0, 0);
    verify_counts("order", 3, 1, 3);
    verify_port_write("order a", 0, 0, 0, aw_a.addr, '0, aw_a, qa);
    verify_port_write("order c", 0, 1, 4, aw_c.addr, '0, aw_c, qc);
    verify_port_write("order b", 3, 0, 0, aw_b.addr, '0, aw_b, qb);
    expect_b("order 0", 0, aw_a.id, RESP_OKAY);
    expect_b("order 1", 1, aw_b.id, RESP_OKAY);
    expect_b("order 2", 2, aw_c.id, RESP_OKAY);
  endtask

  initial begin : main
    arst_n = 1'b0;
    addr_map[0] <= '{start_addr: 32'h1000_0000, end_addr: 32'h1000_1000};
    addr_map[1] <= '{start_addr: 32'h1000_2000, end_addr: 32'h1000_3000};
    addr_map[2] <= '{start_addr: 32'h1000_3000, end_addr: 32'h1000_4000};
    addr_map[3] <= '{start_addr: 32'h1000_8000, end_addr: 32'h1000_9000};
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    unicast_writes();
    decode_error_write();
    default_port_write();
    multicast_write();
    backpressure_order();
    $display("All checks passed");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout, the writes did not complete within %0d ns", TIMEOUT_NS);
    $display("Checks failed");
    $fatal(1);
  end

endmodule

/* verilog.f */
+incdir+.
mcast_bus_pkg.sv
mcast_map_pkg.sv
aw_spill_reg.sv
aw_addr_decode.sv
w_route.sv
b_join.sv
mcast_demux_top.sv
mcast_demux_assertions.sv
mcast_demux_tb.sv

/* Makefile */
# Verilator build and run of the multicast write demultiplexer testbench

VERILATOR ?= verilator
TOP       ?= mcast_demux_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
